// File: audio_board_config.svh
`ifndef AUDIO_BOARD_CONFIG_SVH
`define AUDIO_BOARD_CONFIG_SVH

//----------------------------------------
// Pin clock dividers
//----------------------------------------

`define MIC_SCK_HALF     4    // clk per sck half period, sck = clk / 8
`define AUDIO_BCLK_HALF  4    // clk per bclk half period, bclk = clk / 8

// Frame layout, two slots per frame
`define I2S_SLOT_BITS    32   // Bit clocks per channel slot

//----------------------------------------
// Widths and board resources
//----------------------------------------

`define MIC_BITS         24   // INMP441 sample width
`define SOUND_BITS       16   // DAC word width
`define N_LED            8    // Peak bar length
`define N_KEY            2    // Key 0 is mute
`define N_SW             3    // Volume shift 0 to 7

`endif

// File: audio_board_pkg.sv
`default_nettype none

`include "audio_board_config.svh"

package audio_board_pkg;

    //----------------------------------------
    // Audio data
    //----------------------------------------

    typedef logic signed [`MIC_BITS   - 1:0] mic_sample_t;  // Two's complement, MSB first
    typedef logic signed [`SOUND_BITS - 1:0] sound_t;       // Word sent to the DAC

    //----------------------------------------
    // Pin groups
    //----------------------------------------

    // Lines driven toward the microphone
    typedef struct packed
    {
        logic sck;      // Bit clock
        logic ws;       // Word select, low = left
        logic lr;       // Channel strap, low = left
    } mic_pins_t;

    // Lines driven toward the DAC
    typedef struct packed
    {
        logic mclk;     // Master clock, clk / 2
        logic bclk;     // Bit clock
        logic lrclk;    // Word select, low = left
        logic sdata;    // Serial data, MSB first
    } dac_pins_t;

endpackage

`default_nettype wire

// File: i2s_mic_receiver.sv
`timescale 1ns/10ps
`default_nettype none

`include "audio_board_config.svh"

module i2s_mic_receiver
(
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          sd,
    output audio_board_pkg::mic_pins_t    pins,
    output audio_board_pkg::mic_sample_t  mic_sample,
    output logic                          sample_valid
);

    import audio_board_pkg::*;

    localparam int div_w    = (`MIC_SCK_HALF > 1) ? $clog2(`MIC_SCK_HALF) : 1;
    localparam int frame_w  = $clog2(2 * `I2S_SLOT_BITS);   // 6 bits, 64 sck per frame
    localparam int last_bit = `MIC_BITS;                    // Edge 25 holds the LSB

    logic [div_w   - 1:0] div_cnt;      // Half period counter
    logic                 sck;
    logic [frame_w - 1:0] bit_cnt;      // sck periods since frame start
    logic [frame_w - 1:0] bit_next;
    logic                 half_tick;
    logic                 sck_rise;
    logic                 sck_fall;
    mic_sample_t          shift_reg;    // Last 24 captured bits

    assign half_tick = (div_cnt == div_w'(`MIC_SCK_HALF - 1));
    assign sck_rise  = half_tick & ~sck;    // sck goes high this clk
    assign sck_fall  = half_tick &  sck;    // sck goes low this clk
    assign bit_next  = bit_cnt + 1'b1;

    //----------------------------------------
    // sck generation
    //----------------------------------------

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            div_cnt <= '0;
            sck     <= 1'b0;
        end
        else if (half_tick)
        begin
            div_cnt <= '0;
            sck     <= ~sck;
        end
        else
        begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // Frame position, advanced on falling sck so ws moves there too
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            bit_cnt <= '0;
        else if (sck_fall)
            bit_cnt <= bit_next;            // Wraps at 64
    end

    //----------------------------------------
    // Data capture
    //----------------------------------------

    always_ff @(posedge clk)
    begin
        if (sck_rise)
            shift_reg <= {shift_reg[`MIC_BITS - 2:0], sd};  // MSB arrives first
    end

    // Full left word on rising edges 2 to 25 after ws falls
    always_ff @(posedge clk)
    begin
        if (sck_rise && bit_cnt == frame_w'(last_bit))
            mic_sample <= {shift_reg[`MIC_BITS - 2:0], sd};
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            sample_valid <= 1'b0;
        else
            sample_valid <= sck_rise && (bit_cnt == frame_w'(last_bit));  // One clk strobe
    end

    //----------------------------------------
    // Pins
    //----------------------------------------

    assign pins.sck = sck;
    assign pins.ws  = bit_cnt[frame_w - 1];   // High for the right slot
    assign pins.lr  = 1'b0;                   // Mic answers in the left slot

endmodule

`default_nettype wire

// File: audio_level_core.sv
`timescale 1ns/10ps
`default_nettype none

`include "audio_board_config.svh"

module audio_level_core
(
    input  logic                          clk,
    input  logic                          rst,
    input  audio_board_pkg::mic_sample_t  mic_sample,
    input  logic                          sample_valid,
    input  logic [`N_KEY - 1:0]           key,
    input  logic [`N_SW  - 1:0]           sw,
    output audio_board_pkg::sound_t       sound,
    output logic [`N_LED - 1:0]           led
);

    import audio_board_pkg::*;

    localparam int bar_hi = `SOUND_BITS - 2;        // Bit 14, just below the sign
    localparam int bar_lo = bar_hi - `N_LED + 1;    // Bit 7

    sound_t                    trunc;       // Upper half of the mic word
    sound_t                    scaled;      // After volume shift
    sound_t                    sound_next;
    logic [`SOUND_BITS - 1:0]  magnitude;
    logic [`N_LED      - 1:0]  bar_bits;    // Magnitude bits 14..7
    logic [`N_LED      - 1:0]  led_next;

    //----------------------------------------
    // Sound word
    //----------------------------------------

    // Drop the 8 LSBs of the 24-bit sample
    assign trunc = mic_sample[`MIC_BITS - 1 -: `SOUND_BITS];

    // Volume, larger switch value means quieter
    assign scaled = trunc >>> sw;           // Arithmetic, keeps the sign

    assign sound_next = key[0] ? '0 : scaled;   // Key 0 held = mute

    //----------------------------------------
    // Peak bar
    //----------------------------------------

    // -32768 maps to 0x8000, whose bar bits are all clear
    assign magnitude = sound_next[`SOUND_BITS - 1] ? -sound_next : sound_next;

    assign bar_bits = magnitude[bar_hi:bar_lo];

    // LED i lit when any bar bit at or above i is set
    always_comb
    begin
        for (int i = 0; i < `N_LED; i++)
            led_next[i] = |(bar_bits >> i);
    end

    //----------------------------------------
    // Output registers
    //----------------------------------------

    // Both update one clk after the strobe
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            sound <= '0;
            led   <= '0;
        end
        else if (sample_valid)
        begin
            sound <= sound_next;
            led   <= led_next;      // Bar of the same word
        end
    end

endmodule

`default_nettype wire

// File: i2s_audio_out.sv
`timescale 1ns/10ps
`default_nettype none

`include "audio_board_config.svh"

module i2s_audio_out
(
    input  logic                        clk,
    input  logic                        rst,
    input  audio_board_pkg::sound_t     sound,
    output audio_board_pkg::dac_pins_t  pins
);

    import audio_board_pkg::*;

    localparam int div_w   = (`AUDIO_BCLK_HALF > 1) ? $clog2(`AUDIO_BCLK_HALF) : 1;
    localparam int frame_w = $clog2(2 * `I2S_SLOT_BITS);   // 64 bclk per frame
    localparam int slot_w  = $clog2(`I2S_SLOT_BITS);       // 32 bclk per slot

    logic                 mclk;
    logic [div_w   - 1:0] div_cnt;
    logic                 bclk;
    logic                 half_tick;
    logic                 bclk_fall;
    logic [frame_w - 1:0] bit_cnt;      // bclk periods since frame start
    logic [frame_w - 1:0] bit_next;
    logic                 slot_start;
    logic                 frame_start;
    sound_t               word;         // Held for both slots
    sound_t               shift_reg;
    logic                 sdata;

    assign half_tick   = (div_cnt == div_w'(`AUDIO_BCLK_HALF - 1));
    assign bclk_fall   = half_tick & bclk;
    assign bit_next    = bit_cnt + 1'b1;
    assign slot_start  = (bit_next[slot_w - 1:0] == '0);   // Next bclk opens a slot
    assign frame_start = (bit_next == '0);                 // lrclk falls next

    //----------------------------------------
    // Clocks
    //----------------------------------------

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            mclk <= 1'b0;
        else
            mclk <= ~mclk;          // clk / 2
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            div_cnt <= '0;
            bclk    <= 1'b0;
        end
        else if (half_tick)
        begin
            div_cnt <= '0;
            bclk    <= ~bclk;
        end
        else
        begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            bit_cnt <= '0;
        else if (bclk_fall)
            bit_cnt <= bit_next;    // MSB is lrclk
    end

    //----------------------------------------
    // Serializer
    //----------------------------------------

    // Same word in both slots, zeros after the LSB
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            word      <= '0;
            shift_reg <= '0;
            sdata     <= 1'b0;
        end
        else if (bclk_fall)
        begin
            if (frame_start)
                word <= sound;              // Sample at lrclk fall

            if (slot_start)
            begin
                shift_reg <= frame_start ? sound : word;
                sdata     <= 1'b0;          // I2S one bit delay
            end
            else
            begin
                shift_reg <= shift_reg << 1;            // Zero fill
                sdata     <= shift_reg[`SOUND_BITS - 1];
            end
        end
    end

    //----------------------------------------
    // Pins
    //----------------------------------------

    assign pins.mclk  = mclk;
    assign pins.bclk  = bclk;
    assign pins.lrclk = bit_cnt[frame_w - 1];   // Low = left slot
    assign pins.sdata = sdata;

endmodule

`default_nettype wire

// File: audio_board_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "audio_board_config.svh"

module audio_board_top
(
    input  logic                        clk,
    input  logic                        rst,
    input  logic [`N_KEY - 1:0]         key,        // Active low at the pin
    input  logic [`N_SW  - 1:0]         sw,
    input  logic                        mic_sd,
    output audio_board_pkg::mic_pins_t  mic,
    output audio_board_pkg::dac_pins_t  dac,
    output logic [`N_LED - 1:0]         led
);

    import audio_board_pkg::*;

    logic [`N_KEY - 1:0] key_pressed;   // High while pressed
    mic_pins_t           mic_raw;
    dac_pins_t           dac_raw;
    mic_sample_t         mic_sample;
    logic                sample_valid;
    sound_t              sound;

    assign key_pressed = ~key;

    //----------------------------------------
    // Audio path
    //----------------------------------------

    i2s_mic_receiver i_microphone
    (
        .clk          ( clk          ),
        .rst          ( rst          ),
        .sd           ( mic_sd       ),
        .pins         ( mic_raw      ),
        .mic_sample   ( mic_sample   ),
        .sample_valid ( sample_valid )
    );

    audio_level_core i_core
    (
        .clk          ( clk          ),
        .rst          ( rst          ),
        .mic_sample   ( mic_sample   ),
        .sample_valid ( sample_valid ),
        .key          ( key_pressed  ),
        .sw           ( sw           ),
        .sound        ( sound        ),
        .led          ( led          )  // Already registered in the core
    );

    i2s_audio_out o_audio
    (
        .clk          ( clk          ),
        .rst          ( rst          ),
        .sound        ( sound        ),
        .pins         ( dac_raw      )
    );

    //----------------------------------------
    // Pin registers
    //----------------------------------------

    // Registered pins keep decode glitches off the board
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            mic <= '0;              // lr low selects left
            dac <= '0;
        end
        else
        begin
            mic <= mic_raw;
            dac <= dac_raw;
        end
    end

endmodule

`default_nettype wire

// File: tb_audio_properties.sv
`timescale 1ns/10ps
`default_nettype none

`include "audio_board_config.svh"

module tb_audio_properties
(
    input logic                        clk,
    input logic                        rst,
    input audio_board_pkg::mic_pins_t  mic,
    input audio_board_pkg::dac_pins_t  dac,
    input logic [`N_LED - 1:0]         led
);

    import audio_board_pkg::*;

    //----------------------------------------
    // Frame clocks follow the bit clocks
    //----------------------------------------

    ws_on_sck_fall: assert property (@(posedge clk) disable iff (rst)
        $changed(mic.ws) |-> $fell(mic.sck))
        else $error("ws moved away from a falling sck");

    lrclk_on_bclk_fall: assert property (@(posedge clk) disable iff (rst)
        $changed(dac.lrclk) |-> $fell(dac.bclk))
        else $error("lrclk moved away from a falling bclk");

    // Thermometer means led + 1 is a power of two
    led_thermometer: assert property (@(posedge clk) disable iff (rst)
        ((led + 1'b1) & led) == '0)
        else $error("led is not a thermometer bar");

    lr_low: assert property (@(posedge clk) !mic.lr)
        else $error("lr left the left channel");

endmodule

bind audio_board_top tb_audio_properties props_i
(
    .clk ( clk ),
    .rst ( rst ),
    .mic ( mic ),
    .dac ( dac ),
    .led ( led )
);

`default_nettype wire

// File: tb_audio_checker.sv
`timescale 1ns/10ps
`default_nettype none

`include "audio_board_config.svh"

module tb_audio_checker
(
    input  logic                        clk,
    input  logic                        rst,
    input  logic [`N_KEY - 1:0]         key,
    input  logic [`N_SW  - 1:0]         sw,
    input  audio_board_pkg::mic_pins_t  mic,
    input  audio_board_pkg::dac_pins_t  dac,
    input  logic [`N_LED - 1:0]         led,
    output int                          frames,
    output int                          value_errors,
    output int                          timing_errors
);

    import audio_board_pkg::*;

    logic [`MIC_BITS - 1:0] word_q[$];     // Filled by the microphone model

    logic [4:0]            pins_now;       // mclk, bclk, sck, lrclk, ws
    logic [4:0]            pins_prev;
    int                    since[5];       // clk since last rising edge
    bit                    seen[5];
    int                    period[5] = '{512, 512, 8, 8, 2};
    string                 pin_name[5] = '{"ws", "lrclk", "sck", "bclk", "mclk"};
    logic [`N_KEY - 1:0]   key_prev;
    logic [`N_SW  - 1:0]   sw_prev;
    logic [5:0]            mic_pos;
    logic [15:0]           model_sound;    // Sound word of the latest strobe
    logic [15:0]           frame_exp;      // Word expected in this frame
    logic [15:0]           left_word;
    logic [31:0]           slot_bits;
    int                    nbits;

    // Upper 16 bits, arithmetic volume shift, mute on key 0 low at the pin
    function automatic logic [15:0] sound_rule(input logic [23:0] w,
                                               input logic [`N_KEY - 1:0] k,
                                               input logic [`N_SW - 1:0] s);
        logic signed [15:0] top;
        top = w[23:8];
        if (!k[0])
            return '0;
        return top >>> s;
    endfunction

    // Bar length is the leading one among magnitude bits 14..7
    function automatic logic [7:0] bar_rule(input logic [15:0] v);
        logic [15:0] mag;
        int          n;
        mag = v[15] ? (~v + 16'd1) : v;
        n   = 0;
        for (int b = 7; b <= 14; b++)
            if (mag[b])
                n = b - 6;
        return 8'((9'd1 << n) - 9'd1);
    endfunction

    //----------------------------------------
    // Pin clock periods
    //----------------------------------------

    task automatic check_periods();
        for (int i = 0; i < 5; i++)
        begin
            since[i]++;
            if (!pins_prev[i] && pins_now[i])
            begin
                if (seen[i] && since[i] != period[i])
                begin
                    timing_errors++;
                    $display("%s period was %0d clk instead of %0d", pin_name[i],
                             since[i], period[i]);
                end
                since[i] = 0;
                seen[i]  = 1'b1;
            end
        end
    endtask

    // One slot of sdata has been collected
    task automatic end_slot();
        logic [15:0] word;
        word = slot_bits[30:15];            // Rises 2 to 17
        if (nbits != 32)
        begin
            timing_errors++;
            $display("DAC slot ended after %0d bit clocks instead of 32", nbits);
        end
        else
        begin
            if (slot_bits[31] || slot_bits[14:0] != '0)
            begin
                value_errors++;
                $display("ERROR sdata padding expected %h actual %h", 32'h0,
                         slot_bits & 32'h80007fff);
            end
            if (!pins_prev[1])
            begin
                if (word !== frame_exp)
                begin
                    value_errors++;
                    $display("ERROR sdata left expected %h actual %h", frame_exp, word);
                end
                left_word = word;
            end
            else
            begin
                if (word !== left_word)
                begin
                    value_errors++;
                    $display("ERROR sdata right expected %h actual %h", left_word, word);
                end
                frames++;
            end
        end
        nbits     = 0;
        slot_bits = '0;
    endtask

    always @(negedge clk)
    begin
        pins_now = {dac.mclk, dac.bclk, mic.sck, dac.lrclk, mic.ws};
        if (rst)
        begin
            if (mic !== '0 || dac !== '0 || led !== '0)
            begin
                value_errors++;
                $display("ERROR pins in reset expected %h actual mic %h dac %h led %h",
                         1'b0, mic, dac, led);
            end
            pins_now    = '0;
            mic_pos     = '0;
            model_sound = '0;
            frame_exp   = '0;
            left_word   = '0;
            slot_bits   = '0;
            nbits       = 0;
            for (int i = 0; i < 5; i++)
            begin
                since[i] = 0;
                seen[i]  = 1'b0;
            end
        end
        else
        begin
            check_periods();

            // Microphone side, sound registered at this sck rise
            if (pins_prev[2] && !mic.sck)
                mic_pos = mic_pos + 1'b1;
            if (!pins_prev[2] && mic.sck && mic_pos == 6'd24)
            begin
                if (word_q.size() == 0)
                begin
                    value_errors++;
                    $display("Sample strobe came with no microphone word sent");
                end
                else
                    model_sound = sound_rule(word_q.pop_front(), key_prev, sw_prev);
            end

            // DAC side
            if (dac.lrclk != pins_prev[1])
            begin
                end_slot();
                if (!dac.lrclk)             // New frame latches the latest sound
                begin
                    frame_exp = model_sound;
                    if (led !== bar_rule(model_sound))
                    begin
                        value_errors++;
                        $display("ERROR led expected %h actual %h", bar_rule(model_sound), led);
                    end
                end
            end
            if (!pins_prev[3] && dac.bclk)
            begin
                slot_bits = {slot_bits[30:0], dac.sdata};
                nbits++;
            end
        end
        pins_prev = pins_now;
        key_prev  = key;                    // Value in force at next edge
        sw_prev   = sw;
    end

    initial
    begin
        frames        = 0;
        value_errors  = 0;
        timing_errors = 0;
        pins_prev     = '0;
    end

endmodule

`default_nettype wire

// File: tb_audio_board.sv
`timescale 1ns/10ps
`default_nettype none

`include "audio_board_config.svh"

module tb_audio_board;

    import audio_board_pkg::*;

    localparam int frame_clk    = 2 * `I2S_SLOT_BITS * 2 * `AUDIO_BCLK_HALF;  // 512 clk
    localparam int n_frames     = 200;
    localparam int reset_cycles = 10;
    localparam int max_cycles   = (n_frames * frame_clk + reset_cycles) * 11 / 10;
    localparam int seed_init    = 32'hf37ac643;

    logic                  clk;
    logic                  rst;
    logic [`N_KEY - 1:0]   key;
    logic [`N_SW  - 1:0]   sw;
    logic                  mic_sd;
    mic_pins_t             mic;
    dac_pins_t             dac;
    logic [`N_LED - 1:0]   led;

    integer                mic_seed;    // Microphone words and filler bits
    integer                ctl_seed;    // Keys and switches
    int                    cycles;
    int                    frames_done;
    int                    value_errors;
    int                    timing_errors;
    logic [5:0]            mic_pos;     // sck periods into the mic frame
    logic [`MIC_BITS - 1:0] mic_word;

    audio_board_top audio_board_top_i
    (
        .clk    ( clk    ),
        .rst    ( rst    ),
        .key    ( key    ),
        .sw     ( sw     ),
        .mic_sd ( mic_sd ),
        .mic    ( mic    ),
        .dac    ( dac    ),
        .led    ( led    )
    );

    tb_audio_checker monitor_i
    (
        .clk           ( clk           ),
        .rst           ( rst           ),
        .key           ( key           ),
        .sw            ( sw            ),
        .mic           ( mic           ),
        .dac           ( dac           ),
        .led           ( led           ),
        .frames        ( frames_done   ),
        .value_errors  ( value_errors  ),
        .timing_errors ( timing_errors )
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;                   // 10 ns period

    //----------------------------------------
    // Microphone model
    //----------------------------------------

    // Word at positions 1 to 24, sampled by the DUT on the next rising sck
    always @(negedge mic.sck or posedge rst)
    begin
        if (rst)
        begin
            mic_pos = '0;
            mic_sd  = 1'b0;
        end
        else
        begin
            mic_pos = mic_pos + 1'b1;       // Wraps at 64 like ws
            #1;
            if (mic_pos == 6'd1)
            begin
                mic_word = $random(mic_seed);
                monitor_i.word_q.push_back(mic_word);
            end
            if (mic_pos >= 6'd1 && mic_pos <= 6'd24)
                mic_sd = mic_word[24 - mic_pos];    // MSB first
            else
                mic_sd = $random(mic_seed);         // Junk outside the word
        end
    end

    //----------------------------------------
    // Keys and switches
    //----------------------------------------

    initial
    begin
        @(negedge rst);
        forever
        begin
            repeat (3 * frame_clk) @(posedge clk);
            #1;
            key = $random(ctl_seed);
            sw  = $random(ctl_seed);
        end
    end

    // Watchdog
    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles >= max_cycles)
        begin
            $display("Timeout after %0d cycles with %0d of %0d frames decoded",
                     cycles, frames_done, n_frames);
            $display("tests failed");
            $finish;
        end
    end

    //----------------------------------------
    // Main sequence
    //----------------------------------------

    initial
    begin
        mic_seed = seed_init;
        ctl_seed = seed_init;
        cycles   = 0;
        key      = '1;                      // Nothing pressed
        sw       = '0;
        mic_sd   = 1'b0;
        rst      = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        #1;
        rst = 1'b0;

        wait (frames_done >= n_frames);
        @(negedge clk);
        $display("Error counts: value %0d, timing %0d", value_errors, timing_errors);
        if (value_errors == 0 && timing_errors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
+incdir+.
audio_board_pkg.sv
i2s_mic_receiver.sv
audio_level_core.sv
i2s_audio_out.sv
audio_board_top.sv
tb_audio_properties.sv
tb_audio_checker.sv
tb_audio_board.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the audio board testbench with Verilator

rm -rf obj_dir sim.log && \
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_audio_board -f sources.f -o tb_audio_board && \
./obj_dir/tb_audio_board > sim.log 2>&1

cat sim.log 2>/dev/null
grep -q "all tests passed" sim.log 2>/dev/null && echo "PASS" || { echo "FAIL"; exit 1; }
